// File: source/vmem_cfg.svh
`ifndef VMEM_CFG_SVH
`define VMEM_CFG_SVH

`define VMEM_WIDTH    16  // data word

`define VMEM_NUMVBNK  4
`define VMEM_BITVBNK  2
`define VMEM_NUMPBNK  5   // one spare per row
`define VMEM_BITPBNK  3
`define VMEM_NUMVROW  16
`define VMEM_BITVROW  4

// bank in the low bits, row above it
`define VMEM_BITADDR  6

`define VMEM_MAPBITS  15  // five bank indices
`define VMEM_ECCBITS  6
`define VMEM_CODEBITS 21

`endif

// File: source/vmem_pkg.sv
`include "vmem_cfg.svh"

package vmem_pkg;

  localparam int SYNBITS = `VMEM_ECCBITS - 1;         // hamming check bits
  localparam int HAMPOS = `VMEM_MAPBITS + SYNBITS;    // code positions 1..20

  // physical bank of each virtual bank, plus the spare
  typedef struct packed {
    logic [`VMEM_NUMVBNK-1:0][`VMEM_BITPBNK-1:0] pbank;
    logic [`VMEM_BITPBNK-1:0]                    free_bank;
  } map_fields_t;

  typedef union packed {
    logic [`VMEM_MAPBITS-1:0] raw;     // codec view
    map_fields_t              fields;  // lookup view
  } map_word_t;

  typedef struct packed {
    logic [`VMEM_ECCBITS-1:0] ecc;
    map_word_t                data;
  } map_code_t;

  // hamming over positions 1..20, data skips the powers of two,
  // top ecc bit is overall parity
  function automatic map_code_t secded_encode(input map_word_t word);
    map_code_t code;
    int d;
    code.data = word;
    code.ecc = '0;
    d = 0;
    for (int pos = 1; pos <= HAMPOS; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        for (int k = 0; k < SYNBITS; k++) begin
          if (pos[k]) code.ecc[k] = code.ecc[k] ^ word.raw[d];
        end
        d++;
      end
    end
    code.ecc[SYNBITS] = ^{code.ecc[SYNBITS-1:0], word.raw};
    return code;
  endfunction

  function automatic map_word_t secded_check(input map_code_t code,
                                             output logic serr,
                                             output logic derr);
    logic [SYNBITS-1:0] syn;
    logic par;
    map_word_t fixed;
    int d;
    syn = code.ecc[SYNBITS-1:0];
    fixed = code.data;
    par = ^{code.ecc, code.data.raw};
    d = 0;
    for (int pos = 1; pos <= HAMPOS; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        for (int k = 0; k < SYNBITS; k++) begin
          if (pos[k]) syn[k] = syn[k] ^ code.data.raw[d];
        end
        d++;
      end
    end
    // flip the one data bit the syndrome points at
    d = 0;
    for (int pos = 1; pos <= HAMPOS; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        if (par && syn == pos[SYNBITS-1:0]) fixed.raw[d] = ~fixed.raw[d];
        d++;
      end
    end
    serr = par;
    derr = !par && (syn != '0);  // even parity but bad syndrome
    return fixed;
  endfunction

endpackage

// File: source/bank_if.sv
`timescale 1ns/1ns
`include "vmem_cfg.svh"

// per-cycle commands to the physical banks
interface bank_if;

  logic                     rd_en;
  logic [`VMEM_BITPBNK-1:0] rd_bank;
  logic [`VMEM_BITVROW-1:0] rd_row;
  logic [`VMEM_WIDTH-1:0]   rd_data;  // one cycle after rd_en

  logic                     wr_en;
  logic [`VMEM_BITPBNK-1:0] wr_bank;
  logic [`VMEM_BITVROW-1:0] wr_row;
  logic [`VMEM_WIDTH-1:0]   wr_data;

  modport ctrl (
    output rd_en, rd_bank, rd_row,
    output wr_en, wr_bank, wr_row, wr_data,
    input  rd_data
  );

  modport bank (
    input  rd_en, rd_bank, rd_row,
    input  wr_en, wr_bank, wr_row, wr_data,
    output rd_data
  );

endinterface

// File: source/vmem_ctrl.sv
`timescale 1ns/1ns
`include "vmem_cfg.svh"

module vmem_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     read,
  input  logic [`VMEM_BITADDR-1:0] rd_adr,
  input  logic                     write,
  input  logic [`VMEM_BITADDR-1:0] wr_adr,
  input  logic [`VMEM_WIDTH-1:0]   din,
  output logic                     ready,
  output logic                     rd_vld,
  output logic [`VMEM_BITVROW-1:0] map_rd_row,
  output logic [`VMEM_BITVROW-1:0] map_wr_row,
  output logic                     map_we,
  output logic [`VMEM_BITVROW-1:0] map_we_row,
  output vmem_pkg::map_word_t      map_we_word,
  input  vmem_pkg::map_word_t      map_rd_word,
  input  vmem_pkg::map_word_t      map_wr_word,
  bank_if.ctrl                     banks
);

  localparam int VB = `VMEM_BITVBNK;
  localparam int VR = `VMEM_BITVROW;
  localparam int PB = `VMEM_BITPBNK;
  localparam int AD = `VMEM_BITADDR;
  localparam logic [VR-1:0] LAST_ROW = VR'(`VMEM_NUMVROW - 1);

  logic [VR-1:0]          init_cnt;
  logic                   s1_rd;
  logic                   s1_wr;
  logic [AD-1:0]          s1_rd_adr;
  logic [AD-1:0]          s1_wr_adr;
  logic [`VMEM_WIDTH-1:0] s1_din;
  logic [VB-1:0]          rd_vbnk;
  logic [VB-1:0]          wr_vbnk;
  logic [PB-1:0]          rd_pbank;
  logic [PB-1:0]          wr_pbank;
  logic                   conflict;
  vmem_pkg::map_word_t    ident_word;
  vmem_pkg::map_word_t    remap_word;

  // lookups go out with the request, maps come back next cycle
  assign map_rd_row = rd_adr[AD-1:VB];
  assign map_wr_row = wr_adr[AD-1:VB];

  always_ff @(posedge clk) begin
    if (reset) begin
      ready    <= 1'b0;
      init_cnt <= '0;
      s1_rd    <= 1'b0;
      s1_wr    <= 1'b0;
      rd_vld   <= 1'b0;
    end else begin
      if (!ready) begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == LAST_ROW) ready <= 1'b1;
      end
      s1_rd  <= read && ready;
      s1_wr  <= write && ready;
      rd_vld <= s1_rd;  // bank data lands one cycle later
    end
  end

  always_ff @(posedge clk) begin
    s1_rd_adr <= rd_adr;
    s1_wr_adr <= wr_adr;
    s1_din    <= din;
  end

  assign rd_vbnk  = s1_rd_adr[VB-1:0];
  assign wr_vbnk  = s1_wr_adr[VB-1:0];
  assign rd_pbank = map_rd_word.fields.pbank[rd_vbnk];
  assign wr_pbank = map_wr_word.fields.pbank[wr_vbnk];
  assign conflict = s1_rd && s1_wr && (rd_pbank == wr_pbank);

  always_comb begin
    ident_word = '0;
    for (int i = 0; i < `VMEM_NUMVBNK; i++) begin
      ident_word.fields.pbank[i] = PB'(i);
    end
    ident_word.fields.free_bank = PB'(`VMEM_NUMVBNK);
  end

  // displaced write takes the spare, old home becomes the spare
  always_comb begin
    remap_word = map_wr_word;
    remap_word.fields.pbank[wr_vbnk] = map_wr_word.fields.free_bank;
    remap_word.fields.free_bank = wr_pbank;
  end

  assign map_we      = !ready || conflict;
  assign map_we_row  = ready ? s1_wr_adr[AD-1:VB] : init_cnt;
  assign map_we_word = ready ? remap_word : ident_word;

  assign banks.rd_en   = s1_rd;
  assign banks.rd_bank = rd_pbank;
  assign banks.rd_row  = s1_rd_adr[AD-1:VB];
  assign banks.wr_en   = s1_wr;
  assign banks.wr_bank = conflict ? map_wr_word.fields.free_bank : wr_pbank;
  assign banks.wr_row  = s1_wr_adr[AD-1:VB];
  assign banks.wr_data = s1_din;

  // requests taken before init completes must never reach the banks
  a_no_strobe_before_ready: assert property (
    @(posedge clk) disable iff (reset)
    !ready |-> !(banks.rd_en || banks.wr_en)
  );

endmodule

// File: source/map_table.sv
`timescale 1ns/1ns
`include "vmem_cfg.svh"

module map_table (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`VMEM_BITVROW-1:0] rd_row,
  input  logic [`VMEM_BITVROW-1:0] wr_row,
  input  logic                     we,
  input  logic [`VMEM_BITVROW-1:0] we_row,
  input  vmem_pkg::map_word_t      we_word,
  output vmem_pkg::map_word_t      rd_word,
  output vmem_pkg::map_word_t      wr_word,
  output logic                     serr,
  output logic                     derr
);

  vmem_pkg::map_code_t      mem [`VMEM_NUMVROW];
  vmem_pkg::map_code_t      we_code;
  vmem_pkg::map_code_t      rd_code_q;
  vmem_pkg::map_code_t      wr_code_q;
  logic [`VMEM_NUMVROW-1:0] row_set;   // rows holding a valid code word
  logic                     rd_set_q;
  logic                     wr_set_q;
  logic                     rd_serr;
  logic                     rd_derr;
  logic                     wr_serr;
  logic                     wr_derr;

  function automatic logic is_perm(input vmem_pkg::map_word_t w);
    logic [`VMEM_NUMPBNK-1:0] seen;
    seen = '0;
    for (int i = 0; i < `VMEM_NUMVBNK; i++) begin
      seen[w.fields.pbank[i]] = 1'b1;
    end
    seen[w.fields.free_bank] = 1'b1;
    return &seen;
  endfunction

  assign we_code = vmem_pkg::secded_encode(we_word);

  always_ff @(posedge clk) begin
    if (we) mem[we_row] <= we_code;
    // forward a same-edge update
    rd_code_q <= (we && we_row == rd_row) ? we_code : mem[rd_row];
    wr_code_q <= (we && we_row == wr_row) ? we_code : mem[wr_row];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      row_set  <= '0;
      rd_set_q <= 1'b0;
      wr_set_q <= 1'b0;
      serr     <= 1'b0;
      derr     <= 1'b0;
    end else begin
      if (we) row_set[we_row] <= 1'b1;
      rd_set_q <= row_set[rd_row] || (we && we_row == rd_row);
      wr_set_q <= row_set[wr_row] || (we && we_row == wr_row);
      serr     <= rd_set_q && rd_serr;  // lines up with bank read data
      derr     <= rd_set_q && rd_derr;
    end
  end

  always_comb begin
    rd_word = vmem_pkg::secded_check(rd_code_q, rd_serr, rd_derr);
    wr_word = vmem_pkg::secded_check(wr_code_q, wr_serr, wr_derr);
  end

  // remaps in the controller must keep every row a permutation
  a_rd_map_perm: assert property (
    @(posedge clk) disable iff (reset)
    rd_set_q |-> is_perm(rd_word)
  );

  a_wr_map_perm: assert property (
    @(posedge clk) disable iff (reset)
    wr_set_q |-> is_perm(wr_word) && !(wr_serr || wr_derr)
  );

endmodule

// File: source/bank_array.sv
`timescale 1ns/1ns
`include "vmem_cfg.svh"

module bank_array (
  input logic   clk,
  input logic   reset,
  bank_if.bank  banks
);

  localparam int PB = `VMEM_BITPBNK;

  logic [`VMEM_WIDTH-1:0] bank_dout [`VMEM_NUMPBNK];
  logic [PB-1:0]          rd_sel_q;

  for (genvar pb = 0; pb < `VMEM_NUMPBNK; pb++) begin : g_bank
    logic [`VMEM_WIDTH-1:0]   mem [`VMEM_NUMVROW];
    logic [`VMEM_WIDTH-1:0]   dout;
    logic [`VMEM_BITVROW-1:0] addr;
    logic                     wr_hit;
    logic                     rd_hit;

    assign wr_hit = banks.wr_en && (banks.wr_bank == PB'(pb));
    assign rd_hit = banks.rd_en && (banks.rd_bank == PB'(pb));
    assign addr   = wr_hit ? banks.wr_row : banks.rd_row;  // single port

    always_ff @(posedge clk) begin
      if (wr_hit) begin
        mem[addr] <= banks.wr_data;
      end else if (rd_hit) begin
        dout <= mem[addr];
      end
    end

    assign bank_dout[pb] = dout;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_sel_q <= '0;
    end else if (banks.rd_en) begin
      rd_sel_q <= banks.rd_bank;
    end
  end

  assign banks.rd_data = bank_dout[rd_sel_q];

  // the controller steers conflicting writes to the spare bank
  a_no_bank_clash: assert property (
    @(posedge clk) disable iff (reset)
    banks.rd_en && banks.wr_en |-> banks.rd_bank != banks.wr_bank
  );

  a_bank_range: assert property (
    @(posedge clk) disable iff (reset)
    banks.rd_en |-> banks.rd_bank < PB'(`VMEM_NUMPBNK)
  );

endmodule

// File: source/vmem_top.sv
`timescale 1ns/1ns
`include "vmem_cfg.svh"

module vmem_top (
  input  logic                     clk,
  input  logic                     reset,
  output logic                     ready,
  input  logic                     read,
  input  logic [`VMEM_BITADDR-1:0] rd_adr,
  output logic                     rd_vld,
  output logic [`VMEM_WIDTH-1:0]   rd_dout,
  output logic                     rd_serr,
  output logic                     rd_derr,
  input  logic                     write,
  input  logic [`VMEM_BITADDR-1:0] wr_adr,
  input  logic [`VMEM_WIDTH-1:0]   din
);

  logic [`VMEM_BITVROW-1:0] map_rd_row;
  logic [`VMEM_BITVROW-1:0] map_wr_row;
  logic                     map_we;
  logic [`VMEM_BITVROW-1:0] map_we_row;
  vmem_pkg::map_word_t      map_we_word;
  vmem_pkg::map_word_t      map_rd_word;
  vmem_pkg::map_word_t      map_wr_word;

  bank_if banks_if ();

  vmem_ctrl vmem_ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .read        (read),
    .rd_adr      (rd_adr),
    .write       (write),
    .wr_adr      (wr_adr),
    .din         (din),
    .ready       (ready),
    .rd_vld      (rd_vld),
    .map_rd_row  (map_rd_row),
    .map_wr_row  (map_wr_row),
    .map_we      (map_we),
    .map_we_row  (map_we_row),
    .map_we_word (map_we_word),
    .map_rd_word (map_rd_word),
    .map_wr_word (map_wr_word),
    .banks       (banks_if)
  );

  map_table map_table_i (
    .clk     (clk),
    .reset   (reset),
    .rd_row  (map_rd_row),
    .wr_row  (map_wr_row),
    .we      (map_we),
    .we_row  (map_we_row),
    .we_word (map_we_word),
    .rd_word (map_rd_word),
    .wr_word (map_wr_word),
    .serr    (rd_serr),
    .derr    (rd_derr)
  );

  bank_array bank_array_i (
    .clk   (clk),
    .reset (reset),
    .banks (banks_if)
  );

  assign rd_dout = banks_if.rd_data;

endmodule

// File: testbench/vmem_tb.sv
`timescale 1ns/1ns
`include "vmem_cfg.svh"

module vmem_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  localparam int INIT_CYCLES  = 16;
  localparam int READY_LIMIT  = 20;
  localparam int RAND_CYCLES  = 200;
  localparam int READ_LATENCY = 2;
  localparam int MAX_LINES    = 64;
  localparam int AW = `VMEM_BITADDR;
  localparam int DW = `VMEM_WIDTH;
  localparam int RW = `VMEM_BITVROW;
  localparam int BW = `VMEM_BITVBNK;

  logic          clk;
  logic          reset;
  logic          ready;
  logic          read;
  logic [AW-1:0] rd_adr;
  logic          rd_vld;
  logic [DW-1:0] rd_dout;
  logic          rd_serr;
  logic          rd_derr;
  logic          write;
  logic [AW-1:0] wr_adr;
  logic [DW-1:0] din;

  // directed operations, one per line of the file
  logic          dir_rd     [MAX_LINES];
  logic [AW-1:0] dir_rd_adr [MAX_LINES];
  logic          dir_wr     [MAX_LINES];
  logic [AW-1:0] dir_wr_adr [MAX_LINES];
  logic [DW-1:0] dir_din    [MAX_LINES];
  logic [DW-1:0] dir_exp    [MAX_LINES];
  int            n_dir;

  logic          use_file;  // expected data taken from the file
  logic [DW-1:0] file_exp;

  logic [DW-1:0] shadow [1<<AW];
  logic          known  [1<<AW] = '{default: 1'b0};
  logic [DW-1:0] exp_q [$];
  logic          chk_q [$];
  int            cyc_q [$];
  int            cyc = 0;
  int            n_checked = 0;
  logic          armed = 1'b0;
  int            limit_ns;

  vmem_top vmem_top_i (
    .clk     (clk),
    .reset   (reset),
    .ready   (ready),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_serr (rd_serr),
    .rd_derr (rd_derr),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic load_stimulus();
    int fd;
    int n;
    string line;
    logic [31:0] f_rd, f_ra, f_wr, f_wa, f_din, f_exp;
    fd = $fopen("testbench/vmem_stimulus.txt", "r");
    if (fd == 0) begin
      fail_run("could not open testbench/vmem_stimulus.txt");
    end else begin
      n_dir = 0;
      while (!$feof(fd) && n_dir < MAX_LINES) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%h %h %h %h %h %h", f_rd, f_ra, f_wr, f_wa, f_din, f_exp);
        if (n == 6) begin  // comment lines fail the scan
          dir_rd[n_dir]     = f_rd[0];
          dir_rd_adr[n_dir] = AW'(f_ra);
          dir_wr[n_dir]     = f_wr[0];
          dir_wr_adr[n_dir] = AW'(f_wa);
          dir_din[n_dir]    = DW'(f_din);
          dir_exp[n_dir]    = DW'(f_exp);
          n_dir++;
        end
      end
      $fclose(fd);
    end
  endtask

  // keep traffic on the inputs while init runs
  task automatic wait_ready();
    int waited;
    waited = 0;
    while (ready !== 1'b1) begin
      if (waited == READY_LIMIT) begin
        fail_run("ready did not rise within 20 cycles after reset");
      end else begin
        @(posedge clk);
        read   <= 1'b1;
        rd_adr <= AW'($urandom);
        write  <= 1'b1;
        wr_adr <= AW'($urandom);
        din    <= DW'($urandom);
        @(negedge clk);
        waited++;
      end
    end
  endtask

  task automatic drive_random();
    logic [RW-1:0] rrow;
    logic [RW-1:0] wrow;
    logic [BW-1:0] rbnk;
    logic [BW-1:0] wbnk;
    rrow = RW'($urandom % 8);  // few rows, so conflicts repeat
    rbnk = BW'($urandom);
    wrow = ($urandom % 2 == 0) ? rrow : RW'($urandom % 8);
    wbnk = ($urandom % 4 == 0) ? rbnk : BW'($urandom);
    read     <= ($urandom % 4 != 0);
    write    <= ($urandom % 4 != 0);
    rd_adr   <= {rrow, rbnk};
    wr_adr   <= {wrow, wbnk};
    din      <= DW'($urandom);
    use_file <= 1'b0;
  endtask

  task automatic check_read();
    if (exp_q.size() == 0) begin
      fail_run("rd_vld was raised with no read pending");
    end else begin
      check_value("rd_latency", 32'(cyc - cyc_q[0]), 32'(READ_LATENCY));
      if (chk_q[0]) check_value("rd_dout", 32'(rd_dout), 32'(exp_q[0]));
      check_value("rd_serr", 32'(rd_serr), 32'h0);
      check_value("rd_derr", 32'(rd_derr), 32'h0);
      void'(exp_q.pop_front());
      void'(chk_q.pop_front());
      void'(cyc_q.pop_front());
      n_checked++;
    end
  endtask

  // read sees the old word, the write lands after it
  task automatic track_request();
    if (read) begin
      exp_q.push_back(use_file ? file_exp : shadow[rd_adr]);
      chk_q.push_back(use_file || known[rd_adr]);
      cyc_q.push_back(cyc);
    end
    if (write) begin
      shadow[wr_adr] = din;
      known[wr_adr]  = 1'b1;
    end
  endtask

  always @(negedge clk) begin
    cyc = cyc + 1;
    if (!reset) begin
      if (!ready && rd_vld !== 1'b0) begin
        fail_run("rd_vld was raised before ready");
      end else if (rd_vld === 1'b1) begin
        check_read();
      end
      if (ready === 1'b1) track_request();
    end
  end

  initial begin
    wait (armed === 1'b1);
    #(limit_ns);
    fail_run($sformatf("timeout after %0d ns, the test did not finish", limit_ns));
  end

  initial begin
    reset    <= 1'b1;
    read     <= 1'b0;
    rd_adr   <= '0;
    write    <= 1'b0;
    wr_adr   <= '0;
    din      <= '0;
    use_file <= 1'b0;
    file_exp <= '0;
    void'($urandom(32'h8de2));
    load_stimulus();
    limit_ns = (n_dir + RAND_CYCLES + INIT_CYCLES) * 2 * CLK_PERIOD;
    armed = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    wait_ready();

    for (int i = 0; i < n_dir; i++) begin
      @(posedge clk);
      read     <= dir_rd[i];
      rd_adr   <= dir_rd_adr[i];
      write    <= dir_wr[i];
      wr_adr   <= dir_wr_adr[i];
      din      <= dir_din[i];
      file_exp <= dir_exp[i];
      use_file <= 1'b1;
    end

    for (int i = 0; i < RAND_CYCLES; i++) begin
      @(posedge clk);
      drive_random();
    end

    @(posedge clk);
    read  <= 1'b0;
    write <= 1'b0;
    repeat (READ_LATENCY + 2) @(posedge clk);  // drain

    if (exp_q.size() != 0) begin
      fail_run($sformatf("%0d reads never returned data", exp_q.size()));
    end else begin
      $display("%0d reads checked", n_checked);
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// File: src.f
+incdir+source
source/vmem_pkg.sv
source/bank_if.sv
source/vmem_ctrl.sv
source/map_table.sv
source/bank_array.sv
source/vmem_top.sv
testbench/vmem_tb.sv

// File: run.sh
#!/bin/sh
# build from the file list and run, the simulator's exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module vmem_tb -f src.f -o vmem_sim &&
./obj_dir/vmem_sim || exit 1
exit 0

// File: testbench/vmem_stimulus.txt
# read rd_adr write wr_adr din expected_rd_dout, all hex, one operation per clock
# expected_rd_dout is ignored on lines without a read
0 00 1 00 1111 0000
0 00 1 01 2222 0000
0 00 1 02 3333 0000
0 00 1 03 4444 0000
1 00 1 14 5555 1111
1 01 1 15 6666 2222
1 14 1 3f 7777 5555
1 15 1 02 abcd 6666
1 02 1 02 1234 abcd
1 02 1 02 5678 1234
1 02 0 00 0000 5678
1 03 0 00 0000 4444
1 3f 0 00 0000 7777
1 00 0 00 0000 1111
1 01 0 00 0000 2222
1 14 0 00 0000 5555
1 15 0 00 0000 6666
1 3f 1 3e 0f0f 7777
1 3e 1 2b beef 0f0f
1 2b 0 00 0000 beef
1 02 1 02 9999 5678
1 02 0 00 0000 9999
0 00 0 00 0000 0000
